/* Makefile */
SIM      := verilator
TOP      := tb_character_buffer
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/character_buffer_properties.sv */
// Concurrent checks bound into the character buffer top level
`timescale 1ns/1ns

module character_buffer_properties
  import console_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    i_wr_char_rdy,
  input logic    i_char_rdy,
  input ram_wr_t i_wr,
  input logic    i_reader_busy
);

  int unsigned fail_cnt = 0;   // Failed property count

  // Each delivered character is a single-cycle pulse
  a_char_rdy_pulse: assert property (@(posedge clk) disable iff (rst)
    i_char_rdy |=> !i_char_rdy)
  else begin
    fail_cnt++;
    $error("o_char_rdy stayed high for two cycles");
  end

  // Both ready outputs stay low through reset
  a_rdy_low_in_reset: assert property (@(posedge clk)
    rst |=> (!i_wr_char_rdy && !i_char_rdy))
  else begin
    fail_cnt++;
    $error("ready output high during reset");
  end

  a_no_write_in_read: assert property (@(posedge clk) disable iff (rst)
    !(i_wr.we && i_reader_busy))
  else begin
    fail_cnt++;
    $error("RAM write at 0x%0h while the reader is busy", i_wr.addr);
  end

endmodule

bind character_buffer character_buffer_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .i_wr_char_rdy (o_wr_char_rdy),
  .i_char_rdy    (o_char_rdy),
  .i_wr          (wr),
  .i_reader_busy (reader_busy)
);

/* dv/tb_character_buffer.sv */
// Testbench for the text console character buffer with reference model and frame compare
`timescale 1ns/1ns
`include "console_cfg.svh"

module tb_character_buffer
  import ascii_pkg::*;
();

  localparam int          FRAME_PULSES    = `CHAR_IMAGE_SIZE * `FONT_HEIGHT;
  localparam int          N_TESTS         = 6;
  localparam int          WATCHDOG_CYCLES =
      N_TESTS * (`CHAR_IMAGE_SIZE * `FONT_HEIGHT * 4 + `CHAR_IMAGE_SIZE * 4);
  localparam logic [31:0] SEED            = 32'h0d32_dc24;

  // Control codes with no effect on the writer
  localparam char_t IGNORED [8] = '{8'h00, 8'h01, 8'h07, 8'h0b, 8'h0c, 8'h1b, 8'h1f, 8'h7f};

  logic                    clk;
  logic                    rst;
  logic                    i_char_stb;
  char_t                   i_char;
  logic                    i_alt_func_en;
  logic [`TAB_COUNT_W-1:0] i_tab_count;
  logic                    i_clear_screen_stb;
  logic                    o_wr_char_rdy;
  logic                    i_read_frame_stb;
  logic                    i_char_req_en;
  logic                    o_char_rdy;
  char_t                   o_char;

  integer seed;
  integer req_seed;
  int     req_thresh;   // Request enable odds out of 128
  int     err_cnt;
  int     pulse_cnt;
  logic   read_active;
  int     test_num;
  int     test_fails;
  int     test_err_start;

  char_t  model_mem [`CHAR_IMAGE_SIZE];
  int     model_cursor;

  character_buffer u_dut (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_req_en      (i_char_req_en),
    .o_char_rdy         (o_char_rdy),
    .o_char             (o_char)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Blank frame with the cursor at cell 0
  function automatic void clear_model();
    for (int i = 0; i < `CHAR_IMAGE_SIZE; i++) begin
      model_mem[i] = 8'h00;
    end
    model_cursor = 0;
  endfunction

  // Applies one accepted character to the reference frame
  function automatic void apply_to_model(char_t c, logic alt, int tab);
    if (alt || (c >= 8'h20 && c != 8'h7f)) begin
      model_mem[model_cursor] = c;
      model_cursor = (model_cursor + 1) % `CHAR_IMAGE_SIZE;
    end else if (c == BS) begin
      model_mem[model_cursor] = 8'h00;
      if (model_cursor != 0) begin
        model_cursor = model_cursor - 1;
      end
    end else if (c == CR || c == LF) begin
      // Blanks until the cursor reaches the start of a row
      do begin
        model_mem[model_cursor] = 8'h00;
        model_cursor = (model_cursor + 1) % `CHAR_IMAGE_SIZE;
      end while (model_cursor % `CHAR_IMAGE_WIDTH != 0);
    end else if (c == HT) begin
      for (int i = 0; i < tab; i++) begin
        model_mem[model_cursor] = 8'h00;
        model_cursor = (model_cursor + 1) % `CHAR_IMAGE_SIZE;
      end
    end
  endfunction

  // Expected character of the n-th pulse in scan order
  function automatic char_t expected_char(int n);
    int row;
    int col;
    row = n / (`CHAR_IMAGE_WIDTH * `FONT_HEIGHT);
    col = n % `CHAR_IMAGE_WIDTH;   // Font line drops out of the cell index
    return model_mem[row * `CHAR_IMAGE_WIDTH + col];
  endfunction

  function automatic char_t random_printable();
    return 8'h20 + char_t'({$random(seed)} % 95);
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(u_dut.u_props.fail_cnt);
  endfunction

  task automatic wait_wr_rdy();
    @(negedge clk);
    while (!o_wr_char_rdy) @(negedge clk);
  endtask

  task automatic send_char(char_t c, logic alt, int tab);
    wait_wr_rdy();
    @(posedge clk);
    i_char_stb    <= 1'b1;
    i_char        <= c;
    i_alt_func_en <= alt;
    i_tab_count   <= tab[`TAB_COUNT_W-1:0];
    @(posedge clk);
    i_char_stb    <= 1'b0;   // Accepted on this edge
    apply_to_model(c, alt, tab);
  endtask

  task automatic issue_random_op();
    int op;
    op = {$random(seed)} % 8;
    case (op)
      4:       send_char(BS, 1'b0, 0);
      5:       send_char(HT, 1'b0, {$random(seed)} % (1 << `TAB_COUNT_W));
      6:       send_char(CR, 1'b0, 0);
      7:       send_char(LF, 1'b0, 0);
      default: send_char(random_printable(), 1'b0, 0);
    endcase
  endtask

  task automatic read_frame(logic clear_mid);
    wait_wr_rdy();
    pulse_cnt   = 0;
    read_active = 1'b1;
    @(posedge clk);
    i_read_frame_stb <= 1'b1;
    @(posedge clk);
    i_read_frame_stb <= 1'b0;
    if (clear_mid) begin
      i_clear_screen_stb <= 1'b1;   // Stays pending until the scan ends
      @(posedge clk);
      i_clear_screen_stb <= 1'b0;
    end
    while (pulse_cnt < FRAME_PULSES) @(posedge clk);
    wait_wr_rdy();   // Reader idle and any pending clear done
    read_active = 1'b0;
    assert (pulse_cnt == FRAME_PULSES) else begin
      err_cnt++;
      $display("Error: frame read gave %0d pulses instead of %0d", pulse_cnt, FRAME_PULSES);
    end
    if (clear_mid) begin
      clear_model();
    end
  endtask

  task automatic finish_test(string name);
    int errs;
    errs = total_errors() - test_err_start;
    test_num++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      test_fails++;
      $display("Test %0d %s: %0d errors", test_num, name, errs);
    end
    test_err_start = total_errors();
  endtask

  // Compares every delivered character with the model
  always @(negedge clk) begin : compare_proc
    char_t exp_c;
    if (!rst && o_char_rdy) begin
      assert (read_active && pulse_cnt < FRAME_PULSES) else begin
        err_cnt++;
        $display("Error: o_char_rdy pulsed outside a frame read");
      end
      exp_c = expected_char(pulse_cnt % FRAME_PULSES);
      assert (o_char === exp_c) else begin
        err_cnt++;
        $display("** Error: o_char = 0x%02h, expected 0x%02h at pulse %0d",
                 o_char, exp_c, pulse_cnt);
      end
      pulse_cnt++;
    end
  end

  always @(posedge clk) begin : req_en_drive
    integer r;
    r = $random(req_seed);
    i_char_req_en <= (r[6:0] < req_thresh);
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: run did not finish within %0d cycles, the DUT seems hung", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main_seq
    seed               = SEED;
    req_seed           = ~SEED;
    req_thresh         = 112;
    err_cnt            = 0;
    pulse_cnt          = 0;
    read_active        = 1'b0;
    test_num           = 0;
    test_fails         = 0;
    test_err_start     = 0;
    rst                = 1'b1;
    i_char_stb         = 1'b0;
    i_char             = 8'h00;
    i_alt_func_en      = 1'b0;
    i_tab_count        = '0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b0;
    clear_model();
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    wait_wr_rdy();   // Reset clear has to finish
    read_frame(1'b0);
    finish_test("reset clear, blank frame");

    repeat (40) send_char(random_printable(), 1'b0, 0);
    read_frame(1'b0);
    repeat (60) send_char(random_printable(), 1'b0, 0);   // Wraps past the last cell
    read_frame(1'b0);
    finish_test("printable characters with wrap");

    while (model_cursor != 0) send_char(CR, 1'b0, 0);
    send_char(BS, 1'b0, 0);   // At cell 0
    send_char(8'h41, 1'b0, 0);
    send_char(8'h42, 1'b0, 0);
    send_char(BS, 1'b0, 0);
    send_char(HT, 1'b0, 0);
    repeat (48) issue_random_op();
    read_frame(1'b0);
    finish_test("backspace, tab, CR and LF");

    repeat (5) send_char(random_printable(), 1'b0, 0);
    foreach (IGNORED[i]) send_char(IGNORED[i], 1'b0, 3);
    foreach (IGNORED[i]) send_char(IGNORED[i], 1'b1, 3);
    send_char(BS, 1'b1, 0);
    send_char(HT, 1'b1, 5);
    send_char(LF, 1'b1, 0);
    send_char(CR, 1'b1, 0);
    read_frame(1'b0);
    finish_test("ignored codes and alternate glyphs");

    repeat (30) send_char(random_printable(), 1'b0, 0);
    read_frame(1'b1);   // Clear requested during the scan
    read_frame(1'b0);
    repeat (5) send_char(random_printable(), 1'b0, 0);
    read_frame(1'b0);
    finish_test("clear screen");

    req_thresh = 32;   // Heavy back-pressure
    repeat (20) issue_random_op();
    read_frame(1'b0);
    req_thresh = 112;
    finish_test("read with back-pressure");

    $display("Tests run: %0d, tests failing: %0d, errors: %0d",
             test_num, test_fails, total_errors());
    if (total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/ascii_pkg.sv
hw/console_pkg.sv
hw/char_ram.sv
hw/char_writer.sv
hw/frame_reader.sv
hw/character_buffer.sv
dv/character_buffer_properties.sv
dv/tb_character_buffer.sv

/* hw/ascii_pkg.sv */
// Character codes and the control codes the console writer acts on
package ascii_pkg;

  // One character code
  typedef logic [7:0] char_t;

  // Control codes the writer acts on
  typedef enum logic [7:0] {
    BS = 8'h08,   // Backspace
    HT = 8'h09,   // Horizontal tab
    LF = 8'h0a,   // Line feed
    CR = 8'h0d    // Carriage return
  } ascii_ctrl_e;

  // Lowest printable code
  localparam char_t SPACE_CHAR = 8'h20;

  // Delete sits above the printable range and is ignored
  localparam char_t DEL_CHAR   = 8'h7f;

  // Written by backspace, tab, line fill and clear
  localparam char_t BLANK_CHAR = 8'h00;

endpackage

/* hw/char_ram.sv */
// Character RAM with one write port and one registered read port
`timescale 1ns/1ns
`include "console_cfg.svh"

module char_ram
  import ascii_pkg::*;
  import console_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ram_wr_t    i_wr,
  input  cell_addr_t i_rd_addr,
  output char_t      o_rd_data
);

  char_t mem [`CHAR_IMAGE_SIZE];   // One entry per screen cell

  always_ff @(posedge clk) begin
    if (i_wr.we) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // Read data lands one cycle after the address
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

/* hw/char_writer.sv */
// Console writer FSM that decodes characters, moves the cursor and fills or clears cells
`timescale 1ns/1ns
`include "console_cfg.svh"

module char_writer
  import ascii_pkg::*;
  import console_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_char_stb,
  input  char_t                   i_char,
  input  logic                    i_alt_func_en,
  input  logic [`TAB_COUNT_W-1:0] i_tab_count,
  input  logic                    i_clear_screen_stb,
  input  logic                    i_reader_busy,
  output logic                    o_wr_char_rdy,
  output logic                    o_writer_busy,
  output ram_wr_t                 o_wr
);

  localparam cell_addr_t LAST_CELL = cell_addr_t'(`CHAR_IMAGE_SIZE - 1);

  writer_state_e           state;
  cell_addr_t              cursor;
  cell_addr_t              cursor_next;
  cell_addr_t              cur_row_end;
  cell_addr_t              row_end;      // Last cell of the row being filled
  logic [`TAB_COUNT_W-1:0] tab_cnt;      // Blanks still to write
  logic                    clear_req;
  logic                    clear_start;
  logic                    char_acc;
  logic                    is_printable;
  char_t                   char_q;

  // Cursor steps forward and wraps from the last cell to cell 0
  assign cursor_next = (cursor == LAST_CELL) ? '0 : cursor + 1'b1;

  // End of the row that holds the cursor
  assign cur_row_end = cell_addr_t'((cursor / `CHAR_IMAGE_WIDTH) * `CHAR_IMAGE_WIDTH
                                    + (`CHAR_IMAGE_WIDTH - 1));

  assign o_wr_char_rdy = (state == WR_IDLE) && !i_reader_busy && !clear_req;
  assign o_writer_busy = (state != WR_IDLE);
  assign char_acc      = i_char_stb && o_wr_char_rdy;
  assign clear_start   = (state == WR_IDLE) && clear_req && !i_reader_busy;
  assign is_printable  = (i_char >= SPACE_CHAR) && (i_char != DEL_CHAR);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= WR_CLEAR;   // Blank the whole frame after reset
      cursor    <= '0;
      row_end   <= '0;
      tab_cnt   <= '0;
      clear_req <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (clear_start) begin
            cursor <= '0;
            state  <= WR_CLEAR;
          end else if (char_acc) begin
            if (i_alt_func_en) begin
              state <= WR_NORMAL_CHAR;   // Any code stored as a glyph
            end else begin
              case (i_char)
                BS: state <= WR_BACKSPACE;
                HT: begin
                  tab_cnt <= i_tab_count;
                  state   <= WR_TAB_FILL;
                end
                LF, CR: begin
                  row_end <= cur_row_end;
                  state   <= WR_LINE_FILL;
                end
                default: begin
                  if (is_printable) begin
                    state <= WR_NORMAL_CHAR;
                  end
                end
              endcase
            end
          end
        end
        WR_NORMAL_CHAR: begin
          cursor <= cursor_next;
          state  <= WR_IDLE;
        end
        WR_BACKSPACE: begin
          if (cursor != '0) begin
            cursor <= cursor - 1'b1;
          end
          state <= WR_IDLE;
        end
        WR_LINE_FILL: begin
          cursor <= cursor_next;   // Lands on the next row start at the end
          if (cursor == row_end) begin
            state <= WR_IDLE;
          end
        end
        WR_TAB_FILL: begin
          if (tab_cnt == '0) begin
            state <= WR_IDLE;
          end else begin
            tab_cnt <= tab_cnt - 1'b1;
            cursor  <= cursor_next;
          end
        end
        WR_CLEAR: begin
          cursor <= cursor_next;
          if (cursor == LAST_CELL) begin
            state <= WR_IDLE;   // Cursor wraps back to cell 0
          end
        end
        default: state <= WR_IDLE;
      endcase

      // Clear request waits for both sides to go idle
      if (i_clear_screen_stb) begin
        clear_req <= 1'b1;
      end else if (clear_start) begin
        clear_req <= 1'b0;
      end
    end
  end

  // Character held for the write cycle
  always_ff @(posedge clk) begin
    if (char_acc) begin
      char_q <= i_char;
    end
  end

  // RAM write at the cursor follows the state
  always_comb begin
    o_wr.we   = 1'b0;
    o_wr.addr = cursor;
    o_wr.data = BLANK_CHAR;
    case (state)
      WR_NORMAL_CHAR: begin
        o_wr.we   = 1'b1;
        o_wr.data = char_q;
      end
      WR_BACKSPACE, WR_LINE_FILL, WR_CLEAR: o_wr.we = 1'b1;
      WR_TAB_FILL:                          o_wr.we = (tab_cnt != '0);
      default:                              o_wr.we = 1'b0;
    endcase
  end

endmodule

/* hw/character_buffer.sv */
// Text console character buffer top joining the character writer, frame reader and RAM
`timescale 1ns/1ns
`include "console_cfg.svh"

module character_buffer
  import ascii_pkg::*;
  import console_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_char_stb,
  input  char_t                   i_char,
  input  logic                    i_alt_func_en,
  input  logic [`TAB_COUNT_W-1:0] i_tab_count,
  input  logic                    i_clear_screen_stb,
  output logic                    o_wr_char_rdy,
  input  logic                    i_read_frame_stb,
  input  logic                    i_char_req_en,
  output logic                    o_char_rdy,
  output char_t                   o_char
);

  ram_wr_t    wr;
  cell_addr_t rd_addr;
  logic       writer_busy;
  logic       reader_busy;   // Blocks writes during a frame scan

  char_writer u_writer (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_reader_busy      (reader_busy),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .o_writer_busy      (writer_busy),
    .o_wr               (wr)
  );

  frame_reader u_reader (
    .clk              (clk),
    .rst              (rst),
    .i_read_frame_stb (i_read_frame_stb),
    .i_char_req_en    (i_char_req_en),
    .i_writer_busy    (writer_busy),
    .o_rd_addr        (rd_addr),
    .o_char_rdy       (o_char_rdy),
    .o_reader_busy    (reader_busy)
  );

  char_ram u_ram (
    .clk       (clk),
    .rst       (rst),
    .i_wr      (wr),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_char)
  );

endmodule

/* hw/console_cfg.svh */
// Console geometry macros for the text frame size, font height and cell address widths
`ifndef CONSOLE_CFG_SVH
`define CONSOLE_CFG_SVH

// Characters per text row
`define CHAR_IMAGE_WIDTH  16

// Text rows per frame
`define CHAR_IMAGE_HEIGHT 4

// One cell per character on screen
`define CHAR_IMAGE_SIZE   (`CHAR_IMAGE_WIDTH * `CHAR_IMAGE_HEIGHT)

// Scan lines drawn for each text row
`define FONT_HEIGHT       8

// Cell address width that has to reach CHAR_IMAGE_SIZE - 1
`define CONSOLE_DEPTH     6

// Blanks per horizontal tab come in on this many bits
`define TAB_COUNT_W       3

`endif

/* hw/console_pkg.sv */
// Console types shared by the writer, the reader and the character RAM
`include "console_cfg.svh"

package console_pkg;

  import ascii_pkg::*;

  // One character cell in the frame
  typedef logic [`CONSOLE_DEPTH-1:0] cell_addr_t;

  // Single write port into the character RAM
  typedef struct packed {
    logic       we;
    cell_addr_t addr;
    char_t      data;
  } ram_wr_t;

  // Input side FSM
  typedef enum logic [2:0] {
    WR_IDLE        = 3'd0,
    WR_NORMAL_CHAR = 3'd1,
    WR_BACKSPACE   = 3'd2,
    WR_LINE_FILL   = 3'd3,   // CR and LF share it
    WR_TAB_FILL    = 3'd4,
    WR_CLEAR       = 3'd5
  } writer_state_e;

  // Output side FSM
  typedef enum logic [2:0] {
    RD_IDLE           = 3'd0,
    RD_WAIT_WRITER    = 3'd1,
    RD_PRIME          = 3'd2,
    RD_GET_CHAR       = 3'd3,
    RD_GET_CHAR_DELAY = 3'd4
  } reader_state_e;

endpackage

/* hw/frame_reader.sv */
// Frame reader FSM that scans the text frame and repeats each row once per font line
`timescale 1ns/1ns
`include "console_cfg.svh"

module frame_reader
  import console_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_read_frame_stb,
  input  logic       i_char_req_en,
  input  logic       i_writer_busy,
  output cell_addr_t o_rd_addr,
  output logic       o_char_rdy,
  output logic       o_reader_busy
);

  localparam int COL_W  = $clog2(`CHAR_IMAGE_WIDTH);
  localparam int FONT_W = $clog2(`FONT_HEIGHT);

  localparam logic [COL_W-1:0]  COL_LAST       = COL_W'(`CHAR_IMAGE_WIDTH - 1);
  localparam logic [FONT_W-1:0] FONT_LAST      = FONT_W'(`FONT_HEIGHT - 1);
  localparam cell_addr_t        ROW_STEP       = cell_addr_t'(`CHAR_IMAGE_WIDTH);
  localparam cell_addr_t        LAST_ROW_START =
      cell_addr_t'(`CHAR_IMAGE_SIZE - `CHAR_IMAGE_WIDTH);

  reader_state_e     state;
  cell_addr_t        rd_addr;
  cell_addr_t        row_start;   // First cell of the text row on screen
  logic [COL_W-1:0]  col;
  logic [FONT_W-1:0] font_line;

  assign o_rd_addr     = rd_addr;
  assign o_reader_busy = (state != RD_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RD_IDLE;
      rd_addr    <= '0;
      row_start  <= '0;
      col        <= '0;
      font_line  <= '0;
      o_char_rdy <= 1'b0;
    end else begin
      o_char_rdy <= 1'b0;
      case (state)
        RD_IDLE: ;
        RD_WAIT_WRITER: begin
          // Hold off until the writer has finished its update
          if (!i_writer_busy) begin
            rd_addr   <= '0;
            row_start <= '0;
            col       <= '0;
            font_line <= '0;
            state     <= RD_PRIME;
          end
        end
        RD_PRIME: state <= RD_GET_CHAR;   // Address settles into the RAM
        RD_GET_CHAR: begin
          if (i_char_req_en) begin
            o_char_rdy <= 1'b1;   // RAM data shows up with the pulse
            state      <= RD_GET_CHAR_DELAY;
            if (col != COL_LAST) begin
              col     <= col + 1'b1;
              rd_addr <= rd_addr + 1'b1;
            end else begin
              col <= '0;
              if (font_line != FONT_LAST) begin
                font_line <= font_line + 1'b1;
                rd_addr   <= row_start;   // Same row again for the next scan line
              end else begin
                font_line <= '0;
                if (row_start == LAST_ROW_START) begin
                  state <= RD_IDLE;   // Frame done
                end else begin
                  row_start <= row_start + ROW_STEP;
                  rd_addr   <= row_start + ROW_STEP;
                end
              end
            end
          end
        end
        RD_GET_CHAR_DELAY: state <= RD_GET_CHAR;
        default:           state <= RD_IDLE;
      endcase

      // A new strobe always restarts the frame
      if (i_read_frame_stb) begin
        state <= RD_WAIT_WRITER;
      end
    end
  end

endmodule
